//--- common/adc_rx_pkg.sv
/* widths, bus map and FIFO word layout shared by the ADC receiver
   FIFO_DEPTH is kept small so that overflow shows up in short runs */
`default_nettype none

package adc_rx_pkg;

    localparam int SAMPLE_W   = 14;
    localparam int WORD_W     = 32;
    localparam int DATA_CNT_W = 24;
    localparam int LOST_W     = 8;
    localparam int BUS_ADD_W  = 16;
    localparam int BUS_DATA_W = 8;
    localparam int FIFO_DEPTH = 16;

    localparam logic [LOST_W-1:0] LOST_MAX = 8'd255;

    // register map
    localparam logic [BUS_ADD_W-1:0] REG_SOFT_RST = 16'd0;
    localparam logic [BUS_ADD_W-1:0] REG_START    = 16'd1;
    localparam logic [BUS_ADD_W-1:0] REG_CONF     = 16'd2;
    localparam logic [BUS_ADD_W-1:0] REG_CNT_HI   = 16'd3;
    localparam logic [BUS_ADD_W-1:0] REG_CNT_MID  = 16'd4;
    localparam logic [BUS_ADD_W-1:0] REG_CNT_LO   = 16'd5;
    localparam logic [BUS_ADD_W-1:0] REG_LOST     = 16'd15;

    localparam logic [BUS_DATA_W-1:0] VERSION = 8'h01;  // read at address 0

    localparam int CONF_SYNC_BIT   = 0;
    localparam int CONF_SINGLE_BIT = 2;

    // fifo word fields
    localparam int HDR_BIT   = 31;
    localparam int ID_MSB    = 30;
    localparam int ID_LSB    = 29;
    localparam int SYNC_BIT  = 28;
    localparam int PREV_MSB  = 27;  // earlier sample, zero in single mode
    localparam int PREV_LSB  = 14;
    localparam int LAST_MSB  = 13;
    localparam int LAST_LSB  = 0;

endpackage

`default_nettype wire

//--- common/adc_cfg_if.sv
/* run configuration from the register block to capture, plus status back
   start and done are single-cycle pulses, the rest are levels */
`timescale 1ns/1ps
`default_nettype none

interface adc_cfg_if;
    import adc_rx_pkg::*;

    logic                  start;            // one cycle
    logic                  start_with_sync;
    logic                  single_data;
    logic [DATA_CNT_W-1:0] data_cnt;         // zero means record forever
    logic                  done;             // one cycle
    logic [LOST_W-1:0]     lost_cnt;

    modport regs_side (
        output start,
        output start_with_sync,
        output single_data,
        output data_cnt,
        input  done,
        input  lost_cnt
    );

    modport cap_side (
        input  start,
        input  start_with_sync,
        input  single_data,
        input  data_cnt,
        output done,
        output lost_cnt
    );

endinterface

`default_nettype wire

//--- rtl/adc_rx_regs.sv
/* byte-wide register file on ADC_ENC, read data one cycle after BUS_RD
   a write to address 0 resets the whole receiver for that cycle */
`timescale 1ns/1ps
`default_nettype none

module adc_rx_regs (
    input  logic                              ADC_ENC,
    input  logic                              RST,
    input  logic [adc_rx_pkg::BUS_ADD_W-1:0]  BUS_ADD,
    input  logic [adc_rx_pkg::BUS_DATA_W-1:0] BUS_DATA_IN,
    input  logic                              BUS_WR,
    input  logic                              BUS_RD,
    output logic [adc_rx_pkg::BUS_DATA_W-1:0] BUS_DATA_OUT,
    output logic                              soft_rst,
    adc_cfg_if.regs_side                      cfg
);
    import adc_rx_pkg::*;

    logic                  clr;
    logic                  start_wr;
    logic [BUS_DATA_W-1:0] conf_reg;
    logic [BUS_DATA_W-1:0] cnt_hi;
    logic [BUS_DATA_W-1:0] cnt_mid;
    logic [BUS_DATA_W-1:0] cnt_lo;
    logic                  done_flag;

    assign soft_rst = BUS_WR && (BUS_ADD == REG_SOFT_RST);
    assign clr      = RST || soft_rst;
    assign start_wr = BUS_WR && (BUS_ADD == REG_START);  // data byte ignored

    assign cfg.start_with_sync = conf_reg[CONF_SYNC_BIT];
    assign cfg.single_data     = conf_reg[CONF_SINGLE_BIT];
    assign cfg.data_cnt        = {cnt_hi, cnt_mid, cnt_lo};

    always_ff @(posedge ADC_ENC) begin
        if (clr) begin
            conf_reg <= '0;
            cnt_hi   <= '0;
            cnt_mid  <= '0;
            cnt_lo   <= '0;
        end else if (BUS_WR) begin
            case (BUS_ADD)
                REG_CONF:    conf_reg <= BUS_DATA_IN;
                REG_CNT_HI:  cnt_hi   <= BUS_DATA_IN;
                REG_CNT_MID: cnt_mid  <= BUS_DATA_IN;
                REG_CNT_LO:  cnt_lo   <= BUS_DATA_IN;
                default: ;
            endcase
        end
    end

    // start pulse lands one cycle after the write
    always_ff @(posedge ADC_ENC) begin
        if (clr) begin
            cfg.start <= 1'b0;
            done_flag <= 1'b1;  // idle counts as done
        end else begin
            cfg.start <= start_wr;
            if (start_wr)
                done_flag <= 1'b0;
            else if (cfg.done)
                done_flag <= 1'b1;
        end
    end

    always_ff @(posedge ADC_ENC) begin
        if (RST) begin
            BUS_DATA_OUT <= '0;
        end else if (BUS_RD) begin
            case (BUS_ADD)
                REG_SOFT_RST: BUS_DATA_OUT <= VERSION;
                REG_START:    BUS_DATA_OUT <= {7'b0, done_flag};
                REG_CONF:     BUS_DATA_OUT <= conf_reg;
                REG_CNT_HI:   BUS_DATA_OUT <= cnt_hi;
                REG_CNT_MID:  BUS_DATA_OUT <= cnt_mid;
                REG_CNT_LO:   BUS_DATA_OUT <= cnt_lo;
                REG_LOST:     BUS_DATA_OUT <= cfg.lost_cnt;
                default:      BUS_DATA_OUT <= '0;  // unmapped
            endcase
        end
    end

endmodule

`default_nettype wire

//--- capture/adc_rx_capture.sv
/* records ADC_IN every cycle of a run and packs FIFO words, no stall possible
   double mode expects an even data_cnt, words hitting a full FIFO are only counted */
`timescale 1ns/1ps
`default_nettype none

module adc_rx_capture #(
    parameter logic [1:0] ADC_ID    = 2'd0,
    parameter logic [0:0] HEADER_ID = 1'b0
) (
    input  logic                            ADC_ENC,
    input  logic                            RST,
    input  logic [adc_rx_pkg::SAMPLE_W-1:0] ADC_IN,
    input  logic                            ADC_SYNC,
    adc_cfg_if.cap_side                     cfg,
    input  logic                            full,
    output logic                            wr_en,
    output logic [adc_rx_pkg::WORD_W-1:0]   wr_data
);
    import adc_rx_pkg::*;

    logic                  prev_sync;
    logic [SAMPLE_W-1:0]   prev_data;
    logic                  sync_rise;
    logic                  sync_wait;
    logic                  start_run;
    logic                  running;
    logic                  rec;
    logic [DATA_CNT_W-1:0] rec_cnt;
    logic [DATA_CNT_W-1:0] cnt_next;
    logic                  last;
    logic                  pair_held;   // first sample of a pair is in prev_data
    logic                  write;
    logic [WORD_W-1:0]     word;

    assign sync_rise = ADC_SYNC && !prev_sync;
    assign start_run = cfg.start_with_sync ? (sync_wait && sync_rise) : cfg.start;
    assign rec       = start_run || running;  // sample at the coming edge is recorded
    assign cnt_next  = start_run ? DATA_CNT_W'(1) : rec_cnt + 1'b1;
    assign last      = (cfg.data_cnt != '0) && (cnt_next == cfg.data_cnt);

    // double mode writes on the second sample of each pair
    assign write = rec && (cfg.single_data || (pair_held && !start_run));

    always_ff @(posedge ADC_ENC) begin
        if (RST)
            sync_wait <= 1'b0;
        else if (cfg.start)
            sync_wait <= 1'b1;
        else if (sync_rise)
            sync_wait <= 1'b0;
    end

    always_ff @(posedge ADC_ENC) begin
        if (RST) begin
            running   <= 1'b0;
            rec_cnt   <= '0;
            pair_held <= 1'b0;
            cfg.done  <= 1'b0;
        end else begin
            cfg.done <= rec && last;
            if (rec) begin
                running   <= !last;
                rec_cnt   <= cnt_next;   // wraps harmlessly in endless runs
                pair_held <= start_run ? 1'b1 : !pair_held;
            end
        end
    end

    always_comb begin
        word                    = '0;
        word[HDR_BIT]           = HEADER_ID;
        word[ID_MSB:ID_LSB]     = ADC_ID;
        word[LAST_MSB:LAST_LSB] = ADC_IN;
        if (cfg.single_data) begin
            word[SYNC_BIT] = ADC_SYNC;
        end else begin
            word[SYNC_BIT]          = prev_sync;  // sync of the earlier sample
            word[PREV_MSB:PREV_LSB] = prev_data;
        end
    end

    always_ff @(posedge ADC_ENC) begin
        if (RST) begin
            prev_sync <= 1'b0;
            wr_en     <= 1'b0;
        end else begin
            prev_sync <= ADC_SYNC;
            wr_en     <= write;
        end
    end

    always_ff @(posedge ADC_ENC) begin
        prev_data <= ADC_IN;
        wr_data   <= word;
    end

    // FIFO drops a write while full, count it here
    always_ff @(posedge ADC_ENC) begin
        if (RST)
            cfg.lost_cnt <= '0;
        else if (wr_en && full && cfg.lost_cnt != LOST_MAX)
            cfg.lost_cnt <= cfg.lost_cnt + 1'b1;
    end

endmodule

`default_nettype wire

//--- rtl/adc_rx_fifo.sv
/* single-clock FIFO, head word visible on rd_data while not empty
   writes when full and reads when empty are ignored */
`timescale 1ns/1ps
`default_nettype none

module adc_rx_fifo #(
    parameter int DEPTH = adc_rx_pkg::FIFO_DEPTH
) (
    input  logic                          ADC_ENC,
    input  logic                          RST,
    input  logic                          wr_en,
    input  logic [adc_rx_pkg::WORD_W-1:0] wr_data,
    input  logic                          rd_en,
    output logic [adc_rx_pkg::WORD_W-1:0] rd_data,
    output logic                          full,
    output logic                          empty
);
    import adc_rx_pkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(DEPTH - 1);
    localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(DEPTH);

    logic [WORD_W-1:0] mem [DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;
    logic              push;
    logic              pop;

    assign full    = (count == CNT_FULL);
    assign empty   = (count == '0);
    assign push    = wr_en && !full;
    assign pop     = rd_en && !empty;
    assign rd_data = mem[rd_ptr];  // fall-through

    always_ff @(posedge ADC_ENC) begin
        if (push)
            mem[wr_ptr] <= wr_data;
    end

    always_ff @(posedge ADC_ENC) begin
        if (RST) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push)
                wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // idle or both
            endcase
        end
    end

endmodule

`default_nettype wire

//--- rtl/adc_rx_core.sv
/* single-channel 14-bit ADC receiver, bus and capture both on ADC_ENC
   soft reset clears configuration, lost count and FIFO like RST */
`timescale 1ns/1ps
`default_nettype none

module adc_rx_core #(
    parameter logic [1:0] ADC_ID    = 2'd0,
    parameter logic [0:0] HEADER_ID = 1'b0
) (
    input  logic                              ADC_ENC,
    input  logic                              RST,
    input  logic [adc_rx_pkg::SAMPLE_W-1:0]   ADC_IN,
    input  logic                              ADC_SYNC,
    input  logic [adc_rx_pkg::BUS_ADD_W-1:0]  BUS_ADD,
    input  logic [adc_rx_pkg::BUS_DATA_W-1:0] BUS_DATA_IN,
    input  logic                              BUS_WR,
    input  logic                              BUS_RD,
    output logic [adc_rx_pkg::BUS_DATA_W-1:0] BUS_DATA_OUT,
    input  logic                              FIFO_READ,
    output logic [adc_rx_pkg::WORD_W-1:0]     FIFO_DATA,
    output logic                              FIFO_EMPTY,
    output logic                              LOST_ERROR
);
    import adc_rx_pkg::*;

    logic              soft_rst;
    logic              blk_rst;
    logic              wr_en;
    logic [WORD_W-1:0] wr_data;
    logic              full;

    adc_cfg_if cfg ();

    assign blk_rst    = RST || soft_rst;
    assign LOST_ERROR = (cfg.lost_cnt != '0);

    adc_rx_regs u_regs (
        .ADC_ENC      (ADC_ENC),
        .RST          (RST),       // soft reset handled inside
        .BUS_ADD      (BUS_ADD),
        .BUS_DATA_IN  (BUS_DATA_IN),
        .BUS_WR       (BUS_WR),
        .BUS_RD       (BUS_RD),
        .BUS_DATA_OUT (BUS_DATA_OUT),
        .soft_rst     (soft_rst),
        .cfg          (cfg.regs_side)
    );

    adc_rx_capture #(
        .ADC_ID    (ADC_ID),
        .HEADER_ID (HEADER_ID)
    ) u_capture (
        .ADC_ENC  (ADC_ENC),
        .RST      (blk_rst),
        .ADC_IN   (ADC_IN),
        .ADC_SYNC (ADC_SYNC),
        .cfg      (cfg.cap_side),
        .full     (full),
        .wr_en    (wr_en),
        .wr_data  (wr_data)
    );

    adc_rx_fifo #(
        .DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .ADC_ENC (ADC_ENC),
        .RST     (blk_rst),
        .wr_en   (wr_en),
        .wr_data (wr_data),
        .rd_en   (FIFO_READ),
        .rd_data (FIFO_DATA),
        .full    (full),
        .empty   (FIFO_EMPTY)
    );

endmodule

`default_nettype wire

//--- bench/adc_rx_checker.sv
/* reference model of the receiver, sampled at the falling edge of ADC_ENC
   assumes the configuration stays unchanged while a run is in progress */
`timescale 1ns/1ps
`default_nettype none

module adc_rx_checker #(
    parameter logic [1:0] ADC_ID    = 2'd0,
    parameter logic [0:0] HEADER_ID = 1'b0
) (
    input logic                              ADC_ENC,
    input logic                              RST,
    input logic [adc_rx_pkg::SAMPLE_W-1:0]   ADC_IN,
    input logic                              ADC_SYNC,
    input logic [adc_rx_pkg::BUS_ADD_W-1:0]  BUS_ADD,
    input logic [adc_rx_pkg::BUS_DATA_W-1:0] BUS_DATA_IN,
    input logic                              BUS_WR,
    input logic                              FIFO_READ,
    input logic [adc_rx_pkg::WORD_W-1:0]     FIFO_DATA,
    input logic                              FIFO_EMPTY,
    input logic                              LOST_ERROR
);
    import adc_rx_pkg::*;

    int                    errors = 0;
    logic [WORD_W-1:0]     exp_q [$];     // model of the FIFO contents
    logic [WORD_W-1:0]     pend_word;     // word on its way into the FIFO
    logic                  pend = 1'b0;
    logic [LOST_W-1:0]     lost = '0;
    logic [BUS_DATA_W-1:0] conf = '0;
    logic [DATA_CNT_W-1:0] cnt = '0;
    logic [DATA_CNT_W-1:0] left;
    logic                  run = 1'b0;
    logic                  wait_sync = 1'b0;
    logic                  start_pend = 1'b0;
    logic                  begin_now;
    logic                  phase;
    logic [SAMPLE_W-1:0]   held_data;
    logic                  held_sync;
    logic                  last_sync;
    logic                  clr;

    function automatic int check_value(input string name, input logic [WORD_W-1:0] expected,
                                       input logic [WORD_W-1:0] actual);
        if (actual === expected)
            return 0;
        $display("[ERROR] %0t %s expected %h actual %h", $time, name, expected, actual);
        return 1;
    endfunction

    // inputs change 5 ns after the rising edge, so here they show what the next edge sees
    always @(negedge ADC_ENC) begin
        clr = RST || (BUS_WR && BUS_ADD == REG_SOFT_RST);
        errors += check_value("LOST_ERROR", WORD_W'(lost != '0), WORD_W'(LOST_ERROR));
        if (clr) begin
            exp_q.delete();
            pend       = 1'b0;
            lost       = '0;
            conf       = '0;
            cnt        = '0;
            run        = 1'b0;
            wait_sync  = 1'b0;
            start_pend = 1'b0;
        end else begin
            if (pend) begin  // full is judged before this edge's pop
                if (exp_q.size() < FIFO_DEPTH)
                    exp_q.push_back(pend_word);
                else if (lost != LOST_MAX)
                    lost = lost + 8'd1;
            end
            pend = 1'b0;
            if (FIFO_READ && !FIFO_EMPTY) begin
                if (exp_q.size() == 0) begin
                    $display("FIFO gave a word at %0t that no recorded sample produced", $time);
                    errors++;
                end else begin
                    errors += check_value("FIFO_DATA", exp_q.pop_front(), FIFO_DATA);
                end
            end
            begin_now = 1'b0;
            if (start_pend) begin
                if (conf[CONF_SYNC_BIT])
                    wait_sync = 1'b1;
                else
                    begin_now = 1'b1;
            end else if (wait_sync && ADC_SYNC && !last_sync) begin
                wait_sync = 1'b0;
                begin_now = 1'b1;
            end
            if (begin_now) begin
                run   = 1'b1;
                left  = cnt;
                phase = 1'b0;
            end
            if (run) begin
                if (conf[CONF_SINGLE_BIT]) begin
                    pend      = 1'b1;
                    pend_word = {HEADER_ID, ADC_ID, ADC_SYNC, 14'd0, ADC_IN};
                end else if (phase) begin
                    pend      = 1'b1;
                    pend_word = {HEADER_ID, ADC_ID, held_sync, held_data, ADC_IN};
                end
                phase     = !phase;
                held_data = ADC_IN;
                held_sync = ADC_SYNC;
                if (cnt != '0) begin  // zero count never ends
                    left = left - 24'd1;
                    if (left == '0)
                        run = 1'b0;
                end
            end
            start_pend = BUS_WR && BUS_ADD == REG_START;
            if (BUS_WR && BUS_ADD == REG_CONF)
                conf = BUS_DATA_IN;
            if (BUS_WR && BUS_ADD == REG_CNT_HI)
                cnt[23:16] = BUS_DATA_IN;
            if (BUS_WR && BUS_ADD == REG_CNT_MID)
                cnt[15:8] = BUS_DATA_IN;
            if (BUS_WR && BUS_ADD == REG_CNT_LO)
                cnt[7:0] = BUS_DATA_IN;
        end
        last_sync = ADC_SYNC;
    end

endmodule

`default_nettype wire

//--- bench/adc_rx_tb.sv
/* testbench for adc_rx_core, one capture run per pattern-file line
   each run ends with a soft reset, so every case starts from a clean receiver */
`timescale 1ns/1ps
`default_nettype none

module adc_rx_tb;
    import adc_rx_pkg::*;

    localparam logic [1:0] ADC_ID     = 2'd2;
    localparam logic [0:0] HEADER_ID  = 1'b1;
    localparam int         DONE_POLLS = 200;
    localparam int         EMPTY_WAIT = 100;

    logic                  ADC_ENC;
    logic                  RST;
    logic [SAMPLE_W-1:0]   ADC_IN;
    logic                  ADC_SYNC;
    logic [BUS_ADD_W-1:0]  BUS_ADD;
    logic [BUS_DATA_W-1:0] BUS_DATA_IN;
    logic                  BUS_WR;
    logic                  BUS_RD;
    logic [BUS_DATA_W-1:0] BUS_DATA_OUT;
    logic                  FIFO_READ;
    logic [WORD_W-1:0]     FIFO_DATA;
    logic                  FIFO_EMPTY;
    logic                  LOST_ERROR;

    logic [3:0]            sync_cnt;
    logic [SAMPLE_W-1:0]   ramp_start;
    int                    ramp_req;      // bumped to reload the ramp
    int                    ramp_seen;
    int                    bench_errors;
    int                    timeouts;
    int                    fd;
    int                    fields;
    string                 line;
    logic [BUS_DATA_W-1:0] p_conf;
    logic [DATA_CNT_W-1:0] p_cnt;
    logic [SAMPLE_W-1:0]   p_ramp;
    int                    p_nread;
    logic [LOST_W-1:0]     p_lost;

    adc_rx_core #(.ADC_ID(ADC_ID), .HEADER_ID(HEADER_ID)) dut0 (
        .ADC_ENC(ADC_ENC), .RST(RST), .ADC_IN(ADC_IN), .ADC_SYNC(ADC_SYNC),
        .BUS_ADD(BUS_ADD), .BUS_DATA_IN(BUS_DATA_IN), .BUS_WR(BUS_WR), .BUS_RD(BUS_RD),
        .BUS_DATA_OUT(BUS_DATA_OUT), .FIFO_READ(FIFO_READ), .FIFO_DATA(FIFO_DATA),
        .FIFO_EMPTY(FIFO_EMPTY), .LOST_ERROR(LOST_ERROR)
    );

    adc_rx_checker #(.ADC_ID(ADC_ID), .HEADER_ID(HEADER_ID)) chk0 (
        .ADC_ENC(ADC_ENC), .RST(RST), .ADC_IN(ADC_IN), .ADC_SYNC(ADC_SYNC),
        .BUS_ADD(BUS_ADD), .BUS_DATA_IN(BUS_DATA_IN), .BUS_WR(BUS_WR),
        .FIFO_READ(FIFO_READ), .FIFO_DATA(FIFO_DATA), .FIFO_EMPTY(FIFO_EMPTY),
        .LOST_ERROR(LOST_ERROR)
    );

    initial begin
        ADC_ENC = 1'b0;
        forever #50 ADC_ENC = ~ADC_ENC;
    end

    // ramp and 16-cycle sync square wave
    initial begin
        ADC_IN    = '0;
        ADC_SYNC  = 1'b0;
        sync_cnt  = '0;
        ramp_seen = 0;
        forever begin
            @(posedge ADC_ENC);
            #5;
            sync_cnt = sync_cnt + 4'd1;
            ADC_SYNC = sync_cnt[3];
            if (ramp_req != ramp_seen) begin
                ramp_seen = ramp_req;
                ADC_IN    = ramp_start;
            end else begin
                ADC_IN = ADC_IN + 14'd1;
            end
        end
    end

    // bus tasks are entered and left 5 ns after a rising edge
    task automatic bus_write(input logic [BUS_ADD_W-1:0] add, input logic [BUS_DATA_W-1:0] data);
        BUS_ADD     = add;
        BUS_DATA_IN = data;
        BUS_WR      = 1'b1;
        @(posedge ADC_ENC);
        #5;
        BUS_WR = 1'b0;
    endtask

    task automatic bus_read(input logic [BUS_ADD_W-1:0] add, output logic [BUS_DATA_W-1:0] data);
        BUS_ADD = add;
        BUS_RD  = 1'b1;
        @(posedge ADC_ENC);
        #5;
        BUS_RD = 1'b0;
        data   = BUS_DATA_OUT;
    endtask

    task automatic check_read(input logic [BUS_ADD_W-1:0] add,
                              input logic [BUS_DATA_W-1:0] expected, input string name);
        logic [BUS_DATA_W-1:0] data;
        bus_read(add, data);
        bench_errors += chk0.check_value(name, WORD_W'(expected), WORD_W'(data));
    endtask

    task automatic wait_done();
        logic [BUS_DATA_W-1:0] flag;
        int                    n;
        flag = '0;
        n    = 0;
        while (flag[0] !== 1'b1 && n < DONE_POLLS) begin
            bus_read(REG_START, flag);
            n++;
        end
        if (flag[0] !== 1'b1) begin
            $display("timeout at %0t: the done flag was never set after start", $time);
            timeouts++;
        end
    endtask

    task automatic pop_word();
        int n;
        int gap;
        n = 0;
        while (FIFO_EMPTY && n < EMPTY_WAIT) begin
            @(posedge ADC_ENC);
            #5;
            n++;
        end
        if (FIFO_EMPTY) begin
            $display("timeout at %0t: the FIFO stayed empty while a word was due", $time);
            timeouts++;
        end else begin
            FIFO_READ = 1'b1;
            @(posedge ADC_ENC);
            #5;
            FIFO_READ = 1'b0;
        end
        gap = $urandom_range(3, 0);
        repeat (gap) begin
            @(posedge ADC_ENC);
            #5;
        end
    endtask

    task automatic run_case(input logic [BUS_DATA_W-1:0] conf, input logic [DATA_CNT_W-1:0] cnt,
                            input logic [SAMPLE_W-1:0] ramp, input int nread,
                            input logic [LOST_W-1:0] exp_lost);
        @(negedge ADC_ENC);
        ramp_start = ramp;
        ramp_req++;
        @(posedge ADC_ENC);
        #5;
        bus_write(REG_CONF, conf);
        bus_write(REG_CNT_HI, cnt[23:16]);
        bus_write(REG_CNT_MID, cnt[15:8]);
        bus_write(REG_CNT_LO, cnt[7:0]);
        check_read(REG_CONF, conf, "conf_reg");
        check_read(REG_CNT_HI, cnt[23:16], "cnt_hi");
        check_read(REG_CNT_MID, cnt[15:8], "cnt_mid");
        check_read(REG_CNT_LO, cnt[7:0], "cnt_lo");
        bus_write(REG_START, 8'h00);
        if (conf[CONF_SYNC_BIT])
            check_read(REG_START, 8'h00, "done_flag");  // still waiting for sync
        wait_done();
        check_read(REG_LOST, exp_lost, "lost_cnt");
        repeat (nread) pop_word();
        bench_errors += chk0.check_value("FIFO_EMPTY", WORD_W'(1'b1), WORD_W'(FIFO_EMPTY));
        bus_write(REG_START, 8'h00);  // second run refills the FIFO before the soft reset
        wait_done();
        bench_errors += chk0.check_value("FIFO_EMPTY", WORD_W'(1'b0), WORD_W'(FIFO_EMPTY));
        bus_write(REG_SOFT_RST, 8'h00);
        check_read(REG_CONF, 8'h00, "conf_reg");
        check_read(REG_LOST, 8'h00, "lost_cnt");
        bench_errors += chk0.check_value("FIFO_EMPTY", WORD_W'(1'b1), WORD_W'(FIFO_EMPTY));
    endtask

    initial begin
        RST          = 1'b1;
        BUS_ADD      = '0;
        BUS_DATA_IN  = '0;
        BUS_WR       = 1'b0;
        BUS_RD       = 1'b0;
        FIFO_READ    = 1'b0;
        ramp_start   = '0;
        ramp_req     = 0;
        bench_errors = 0;
        timeouts     = 0;
        void'($urandom(32'h7482c9c9));
        repeat (2) @(posedge ADC_ENC);
        #5;
        RST = 1'b0;
        check_read(REG_SOFT_RST, VERSION, "version");
        fd = $fopen("bench/adc_rx_patterns.txt", "r");
        if (fd == 0) begin
            $display("could not open the pattern file");
            bench_errors++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() < 2 || line[0] == "#")
                    continue;
                fields = $sscanf(line, "%h %d %h %d %d", p_conf, p_cnt, p_ramp, p_nread, p_lost);
                if (fields == 5) begin
                    run_case(p_conf, p_cnt, p_ramp, p_nread, p_lost);
                end else begin
                    $display("pattern line could not be parsed: %s", line);
                    bench_errors++;
                end
            end
            $fclose(fd);
        end
        $display("errors: %0d, timeouts: %0d", bench_errors + chk0.errors, timeouts);
        if (bench_errors + chk0.errors + timeouts == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

//--- bench/adc_rx_patterns.txt
# conf(hex: bit0 sync, bit2 single)  data_cnt(dec)  ramp_start(hex)  words_to_read  lost
# single without sync, double with wrap, single with sync, double with sync, two overflows
04 8 0100 8 0
00 10 3ff8 5 0
05 6 0200 6 0
01 12 1000 6 0
04 24 0000 16 8
00 40 2000 16 4

//--- tb.f
common/adc_rx_pkg.sv
common/adc_cfg_if.sv
rtl/adc_rx_regs.sv
capture/adc_rx_capture.sv
rtl/adc_rx_fifo.sv
rtl/adc_rx_core.sv
bench/adc_rx_checker.sv
bench/adc_rx_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -f tb.f --top-module adc_rx_tb -o adc_rx_sim
out="$(./obj_dir/adc_rx_sim)"
echo "$out"

if grep -qF '*** PASSED ***' <<< "$out"; then
    exit 0
else
    exit 1
fi
